//--- source/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN  = 64;
    localparam int TAG_W = 4;

    // grouped by the unit that executes them
    typedef enum logic [5:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_addw,
        op_subw,
        op_sllw,
        op_srlw,
        op_sraw,
        op_mul,
        op_mulh,
        op_mulhsu,
        op_mulhu,
        op_mulw,
        op_div,
        op_divu,
        op_rem,
        op_remu,
        op_divw,
        op_divuw,
        op_remw,
        op_remuw,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_jal,
        op_jalr
    } exec_op_e;

    // also the index into per-unit vectors
    typedef enum logic [1:0] {
        unit_alu = 2'd0,
        unit_mul = 2'd1,
        unit_div = 2'd2,
        unit_bru = 2'd3
    } unit_sel_e;

    typedef struct packed {
        exec_op_e         op;
        logic [TAG_W-1:0] tag;
        logic [4:0]       rd;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  rs1_val;
        logic [XLEN-1:0]  rs2_val;
        logic [XLEN-1:0]  imm;
    } exec_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [4:0]       rd;
        logic [XLEN-1:0]  value;
        logic             redirect;
        logic [XLEN-1:0]  target;
    } exec_res_t;

endpackage

`default_nettype wire

//--- source/exec_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module exec_dispatch
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    input  logic [3:0] unit_ready_i,
    output logic [3:0] unit_start_o,
    output exec_req_t unit_req_o
);

    unit_sel_e  sel;
    logic [3:0] avail;
    logic       accept;

    // opcode class
    always_comb begin
        case (req_i.op)
            op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw:
                sel = unit_mul;
            op_div, op_divu, op_rem, op_remu, op_divw, op_divuw, op_remw, op_remuw:
                sel = unit_div;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jal, op_jalr:
                sel = unit_bru;
            default:
                sel = unit_alu;
        endcase
    end

    // a unit being started this cycle still looks idle, so mask it
    assign avail       = unit_ready_i & ~unit_start_o;
    assign req_ready_o = avail[sel];
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            unit_start_o <= 4'b0000;
        end else if (accept) begin
            unit_start_o <= 4'b0001 << sel;
        end else begin
            unit_start_o <= 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            unit_req_o <= req_i;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  exec_req_t req_i,
    output logic      ready_o,
    output logic      res_valid_o,
    output exec_res_t res_o,
    input  logic      grant_i
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] value;
    logic [31:0]     word;
    logic            word_op;

    assign a = req_i.rs1_val;
    assign b = req_i.rs2_val;

    always_comb begin
        value   = '0;
        word    = '0;
        word_op = 1'b0;
        case (req_i.op)
            op_add:  value = a + b;
            op_sub:  value = a - b;
            op_and:  value = a & b;
            op_or:   value = a | b;
            op_xor:  value = a ^ b;
            op_sll:  value = a << b[5:0];
            op_srl:  value = a >> b[5:0];
            op_sra:  value = $signed(a) >>> b[5:0];
            op_slt:  value = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: value = {{(XLEN-1){1'b0}}, a < b};
            // word forms, 5-bit shift amount
            op_addw: begin
                word    = a[31:0] + b[31:0];
                word_op = 1'b1;
            end
            op_subw: begin
                word    = a[31:0] - b[31:0];
                word_op = 1'b1;
            end
            op_sllw: begin
                word    = a[31:0] << b[4:0];
                word_op = 1'b1;
            end
            op_srlw: begin
                word    = a[31:0] >> b[4:0];
                word_op = 1'b1;
            end
            op_sraw: begin
                word    = $signed(a[31:0]) >>> b[4:0];
                word_op = 1'b1;
            end
            default: value = '0;
        endcase
        if (word_op) begin
            value = {{(XLEN-32){word[31]}}, word};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
        end else if (start_i) begin
            res_valid_o <= 1'b1;
        end else if (grant_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            res_o.tag      <= req_i.tag;
            res_o.rd       <= req_i.rd;
            res_o.value    <= value;
            res_o.redirect <= 1'b0;
            res_o.target   <= '0;
        end
    end

    assign ready_o = ~res_valid_o;

endmodule

`default_nettype wire

//--- source/mul_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit
    import exec_pkg::*;
#(
    parameter int WIDTH = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  exec_req_t req_i,
    output logic      ready_o,
    output logic      res_valid_o,
    output exec_res_t res_o,
    input  logic      grant_i
);

    localparam int CNT_W = $clog2(WIDTH);

    typedef enum logic [1:0] {st_idle, st_busy, st_done} state_e;

    state_e             state;
    logic [CNT_W-1:0]   cnt;
    logic               is_w;
    logic               sgn_a;
    logic               sgn_b;
    logic               neg_a;
    logic               neg_b;
    logic [WIDTH-1:0]   op_a;
    logic [WIDTH-1:0]   op_b;
    logic [WIDTH-1:0]   mcand;
    logic [WIDTH:0]     sum;
    logic [2*WIDTH-1:0] acc;
    logic [2*WIDTH-1:0] acc_next;
    logic [2*WIDTH-1:0] prod;
    logic [WIDTH-1:0]   value;
    logic               neg_q;
    exec_op_e           op_q;

    // mulhsu is signed x unsigned
    assign is_w  = (req_i.op == op_mulw);
    assign sgn_a = req_i.op inside {op_mul, op_mulh, op_mulhsu, op_mulw};
    assign sgn_b = req_i.op inside {op_mul, op_mulh, op_mulw};
    assign op_a  = is_w ? {{(WIDTH-32){req_i.rs1_val[31]}}, req_i.rs1_val[31:0]}
                        : req_i.rs1_val[WIDTH-1:0];
    assign op_b  = is_w ? {{(WIDTH-32){req_i.rs2_val[31]}}, req_i.rs2_val[31:0]}
                        : req_i.rs2_val[WIDTH-1:0];
    assign neg_a = sgn_a & op_a[WIDTH-1];
    assign neg_b = sgn_b & op_b[WIDTH-1];

    // one shift-add step, multiplier sits in the low half of acc
    assign sum      = {1'b0, acc[2*WIDTH-1:WIDTH]} + (acc[0] ? {1'b0, mcand} : '0);
    assign acc_next = {sum, acc[WIDTH-1:1]};
    assign prod     = neg_q ? -acc_next : acc_next;

    always_comb begin
        case (op_q)
            op_mul:  value = prod[WIDTH-1:0];
            op_mulw: value = {{(WIDTH-32){prod[31]}}, prod[31:0]};
            default: value = prod[2*WIDTH-1:WIDTH];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: if (start_i) begin
                    state <= st_busy;
                    cnt   <= '0;
                end
                st_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(WIDTH-1)) begin
                        state <= st_done;
                    end
                end
                st_done: if (grant_i) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start_i) begin
            acc            <= {{WIDTH{1'b0}}, neg_b ? -op_b : op_b};
            mcand          <= neg_a ? -op_a : op_a;
            neg_q          <= neg_a ^ neg_b;
            op_q           <= req_i.op;
            res_o.tag      <= req_i.tag;
            res_o.rd       <= req_i.rd;
            res_o.redirect <= 1'b0;
            res_o.target   <= '0;
        end else if (state == st_busy) begin
            acc <= acc_next;
            if (cnt == CNT_W'(WIDTH-1)) begin
                res_o.value <= value;
            end
        end
    end

    assign ready_o     = (state == st_idle);
    assign res_valid_o = (state == st_done);

endmodule

`default_nettype wire

//--- source/div_unit.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit
    import exec_pkg::*;
#(
    parameter int WIDTH = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  exec_req_t req_i,
    output logic      ready_o,
    output logic      res_valid_o,
    output exec_res_t res_o,
    input  logic      grant_i
);

    localparam int CNT_W = $clog2(WIDTH);

    typedef enum logic [1:0] {st_idle, st_busy, st_done} state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    logic             is_sgn;
    logic             is_w;
    logic             is_rem;
    logic             div0;
    logic             ovf;
    logic [WIDTH-1:0] op_a;
    logic [WIDTH-1:0] op_b;
    logic [WIDTH-1:0] special;
    logic [WIDTH-1:0] quo;
    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] dvsr;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   diff;
    logic [WIDTH-1:0] quo_next;
    logic [WIDTH-1:0] rem_next;
    logic [WIDTH-1:0] q_fix;
    logic [WIDTH-1:0] r_fix;
    logic             q_neg_q;
    logic             r_neg_q;
    logic             is_rem_q;
    logic             is_w_q;

    function automatic logic [WIDTH-1:0] fit(input logic [WIDTH-1:0] x, input logic w);
        return w ? {{(WIDTH-32){x[31]}}, x[31:0]} : x;
    endfunction

    assign is_sgn = req_i.op inside {op_div, op_rem, op_divw, op_remw};
    assign is_w   = req_i.op inside {op_divw, op_divuw, op_remw, op_remuw};
    assign is_rem = req_i.op inside {op_rem, op_remu, op_remw, op_remuw};

    // word forms extend from 32 bits by signedness
    assign op_a = is_w ? {{(WIDTH-32){is_sgn & req_i.rs1_val[31]}}, req_i.rs1_val[31:0]}
                       : req_i.rs1_val[WIDTH-1:0];
    assign op_b = is_w ? {{(WIDTH-32){is_sgn & req_i.rs2_val[31]}}, req_i.rs2_val[31:0]}
                       : req_i.rs2_val[WIDTH-1:0];

    // RISC-V results for x/0 and MIN/-1
    assign div0    = (op_b == '0);
    assign ovf     = is_sgn & (&op_b) &
                     (op_a == (is_w ? {{(WIDTH-31){1'b1}}, 31'b0}
                                    : {1'b1, {(WIDTH-1){1'b0}}}));
    assign special = div0 ? (is_rem ? op_a : '1) : (is_rem ? '0 : op_a);

    // restoring step
    assign shifted  = {rem, quo[WIDTH-1]};
    assign diff     = shifted - {1'b0, dvsr};
    assign rem_next = diff[WIDTH] ? shifted[WIDTH-1:0] : diff[WIDTH-1:0];
    assign quo_next = {quo[WIDTH-2:0], ~diff[WIDTH]};
    assign q_fix    = q_neg_q ? -quo_next : quo_next;
    assign r_fix    = r_neg_q ? -rem_next : rem_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: if (start_i) begin
                    state <= (div0 | ovf) ? st_done : st_busy;
                    cnt   <= '0;
                end
                st_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(WIDTH-1)) begin
                        state <= st_done;
                    end
                end
                st_done: if (grant_i) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start_i) begin
            quo            <= (is_sgn & op_a[WIDTH-1]) ? -op_a : op_a;
            dvsr           <= (is_sgn & op_b[WIDTH-1]) ? -op_b : op_b;
            rem            <= '0;
            q_neg_q        <= is_sgn & (op_a[WIDTH-1] ^ op_b[WIDTH-1]);
            r_neg_q        <= is_sgn & op_a[WIDTH-1];
            is_rem_q       <= is_rem;
            is_w_q         <= is_w;
            res_o.tag      <= req_i.tag;
            res_o.rd       <= req_i.rd;
            res_o.value    <= fit(special, is_w);
            res_o.redirect <= 1'b0;
            res_o.target   <= '0;
        end else if (state == st_busy) begin
            quo <= quo_next;
            rem <= rem_next;
            if (cnt == CNT_W'(WIDTH-1)) begin
                res_o.value <= fit(is_rem_q ? r_fix : q_fix, is_w_q);
            end
        end
    end

    assign ready_o     = (state == st_idle);
    assign res_valid_o = (state == st_done);

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  exec_req_t req_i,
    output logic      ready_o,
    output logic      res_valid_o,
    output exec_res_t res_o,
    input  logic      grant_i
);

    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;

    assign eq  = (req_i.rs1_val == req_i.rs2_val);
    assign lt  = $signed(req_i.rs1_val) < $signed(req_i.rs2_val);
    assign ltu = req_i.rs1_val < req_i.rs2_val;

    always_comb begin
        case (req_i.op)
            op_beq:  taken = eq;
            op_bne:  taken = ~eq;
            op_blt:  taken = lt;
            op_bge:  taken = ~lt;
            op_bltu: taken = ltu;
            op_bgeu: taken = ~ltu;
            // jumps always redirect
            default: taken = 1'b1;
        endcase
    end

    assign jalr_sum = req_i.rs1_val + req_i.imm;
    assign target   = (req_i.op == op_jalr) ? {jalr_sum[XLEN-1:1], 1'b0}
                                            : req_i.pc + req_i.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
        end else if (start_i) begin
            res_valid_o <= 1'b1;
        end else if (grant_i) begin
            res_valid_o <= 1'b0;
        end
    end

    // link value is pc+4 for every op
    always_ff @(posedge clk) begin
        if (start_i) begin
            res_o.tag      <= req_i.tag;
            res_o.rd       <= req_i.rd;
            res_o.value    <= req_i.pc + XLEN'(4);
            res_o.redirect <= taken;
            res_o.target   <= target;
        end
    end

    assign ready_o = ~res_valid_o;

endmodule

`default_nettype wire

//--- source/result_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module result_arbiter
    import exec_pkg::*;
(
    input  logic            [3:0] res_valid_i,
    input  exec_res_t       [3:0] res_i,
    output logic            [3:0] grant_o,
    output logic                  res_valid_o,
    output exec_res_t             res_o,
    input  logic                  res_ready_i
);

    unit_sel_e sel;

    // fixed order: branch, alu, mul, div
    always_comb begin
        if (res_valid_i[unit_bru]) begin
            sel = unit_bru;
        end else if (res_valid_i[unit_alu]) begin
            sel = unit_alu;
        end else if (res_valid_i[unit_mul]) begin
            sel = unit_mul;
        end else begin
            sel = unit_div;
        end
    end

    assign res_valid_o = |res_valid_i;
    assign res_o       = res_i[sel];

    // grant only on an actual transfer
    always_comb begin
        grant_o      = 4'b0000;
        grant_o[sel] = res_valid_o & res_ready_i;
    end

endmodule

`default_nettype wire

//--- source/exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_top
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    output logic      res_valid_o,
    output exec_res_t res_o,
    input  logic      res_ready_i
);

    logic      [3:0] unit_ready;
    logic      [3:0] unit_start;
    logic      [3:0] unit_valid;
    logic      [3:0] unit_grant;
    exec_res_t [3:0] unit_res;
    exec_req_t       unit_req;

    exec_dispatch u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .unit_ready_i (unit_ready),
        .unit_start_o (unit_start),
        .unit_req_o   (unit_req)
    );

    alu_unit u_alu (
        .clk         (clk),
        .rst         (rst),
        .start_i     (unit_start[unit_alu]),
        .req_i       (unit_req),
        .ready_o     (unit_ready[unit_alu]),
        .res_valid_o (unit_valid[unit_alu]),
        .res_o       (unit_res[unit_alu]),
        .grant_i     (unit_grant[unit_alu])
    );

    mul_unit #(.WIDTH(XLEN)) u_mul (
        .clk         (clk),
        .rst         (rst),
        .start_i     (unit_start[unit_mul]),
        .req_i       (unit_req),
        .ready_o     (unit_ready[unit_mul]),
        .res_valid_o (unit_valid[unit_mul]),
        .res_o       (unit_res[unit_mul]),
        .grant_i     (unit_grant[unit_mul])
    );

    div_unit #(.WIDTH(XLEN)) u_div (
        .clk         (clk),
        .rst         (rst),
        .start_i     (unit_start[unit_div]),
        .req_i       (unit_req),
        .ready_o     (unit_ready[unit_div]),
        .res_valid_o (unit_valid[unit_div]),
        .res_o       (unit_res[unit_div]),
        .grant_i     (unit_grant[unit_div])
    );

    branch_unit u_bru (
        .clk         (clk),
        .rst         (rst),
        .start_i     (unit_start[unit_bru]),
        .req_i       (unit_req),
        .ready_o     (unit_ready[unit_bru]),
        .res_valid_o (unit_valid[unit_bru]),
        .res_o       (unit_res[unit_bru]),
        .grant_i     (unit_grant[unit_bru])
    );

    result_arbiter u_arb (
        .res_valid_i (unit_valid),
        .res_i       (unit_res),
        .grant_o     (unit_grant),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .res_ready_i (res_ready_i)
    );

endmodule

`default_nettype wire

//--- verif/exec_checker.sv
`timescale 1ns/10ps
`default_nettype none

module exec_checker
    import exec_pkg::*;
#(
    parameter int MAX_VEC = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  logic                req_ready_i,
    input  exec_req_t           req_i,
    input  logic                res_valid_i,
    input  logic                res_ready_i,
    input  exec_res_t           res_i,
    input  logic                end_i,
    output logic [2**TAG_W-1:0] tag_busy_o,
    output int                  value_errors_o,
    output int                  tag_errors_o,
    output int                  missing_errors_o,
    output int                  protocol_errors_o
);

    localparam int FIELDS = 10;
    localparam int NTAG   = 2**TAG_W;

    logic [XLEN-1:0] vec_mem      [0:MAX_VEC*FIELDS-1];
    logic [XLEN-1:0] exp_value    [0:NTAG-1];
    logic            exp_redirect [0:NTAG-1];
    logic [XLEN-1:0] exp_target   [0:NTAG-1];
    logic [4:0]      exp_rd       [0:NTAG-1];
    int              num_vec;
    int              next_vec;
    logic            seen_req;
    logic            end_done;

    initial begin
        value_errors_o    = 0;
        tag_errors_o      = 0;
        missing_errors_o  = 0;
        protocol_errors_o = 0;
        $readmemh("verif/exec_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*FIELDS])) begin
            num_vec++;
        end
    end

    task automatic check_result();
        logic [TAG_W-1:0] t;
        logic             bad;
        t   = res_i.tag;
        bad = 1'b0;
        if (!tag_busy_o[t]) begin
            $display("result with tag %0h arrived with no request of that tag in flight", t);
            tag_errors_o++;
        end else begin
            if (res_i.value !== exp_value[t]) begin
                $display("FAILED %0t: tag %0h value %h, expected %h",
                         $time, t, res_i.value, exp_value[t]);
                bad = 1'b1;
            end
            if (res_i.redirect !== exp_redirect[t]) begin
                $display("FAILED %0t: tag %0h redirect %b, expected %b",
                         $time, t, res_i.redirect, exp_redirect[t]);
                bad = 1'b1;
            end
            if (res_i.target !== exp_target[t]) begin
                $display("FAILED %0t: tag %0h target %h, expected %h",
                         $time, t, res_i.target, exp_target[t]);
                bad = 1'b1;
            end
            if (res_i.rd !== exp_rd[t]) begin
                $display("FAILED %0t: tag %0h rd %0d, expected %0d",
                         $time, t, res_i.rd, exp_rd[t]);
                bad = 1'b1;
            end
            if (bad) begin
                value_errors_o++;
            end
            tag_busy_o[t] <= 1'b0;
        end
    endtask

    // requests arrive in file order, so the next line holds the expected result
    task automatic record_request();
        int base;
        base = next_vec * FIELDS;
        if (next_vec >= num_vec) begin
            $display("more requests were accepted than there are vectors");
            protocol_errors_o++;
        end else if (req_i.tag != vec_mem[base+1][TAG_W-1:0] ||
                     req_i.op != vec_mem[base][5:0]) begin
            $display("accepted request does not match vector %0d", next_vec);
            protocol_errors_o++;
            next_vec++;
        end else begin
            exp_value[req_i.tag]    = vec_mem[base+7];
            exp_redirect[req_i.tag] = vec_mem[base+8][0];
            exp_target[req_i.tag]   = vec_mem[base+9];
            exp_rd[req_i.tag]       = req_i.rd;
            tag_busy_o[req_i.tag]  <= 1'b1;
            next_vec++;
        end
    endtask

    task automatic report_missing();
        for (int t = 0; t < NTAG; t++) begin
            if (tag_busy_o[t]) begin
                $display("result for tag %0h never arrived", t);
                missing_errors_o++;
            end
        end
        if (next_vec < num_vec) begin
            $display("%0d vectors were never accepted by the DUT", num_vec - next_vec);
            missing_errors_o += num_vec - next_vec;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            tag_busy_o <= '0;
            seen_req   <= 1'b0;
            end_done   <= 1'b0;
            next_vec    = 0;
        end else begin
            if ($isunknown(res_valid_i)) begin
                $display("res_valid_o is unknown at time %0t", $time);
                protocol_errors_o++;
            end else if (res_valid_i && !seen_req) begin
                $display("res_valid_o went high before any request was accepted");
                protocol_errors_o++;
            end
            if (res_valid_i === 1'b1 && res_ready_i) begin
                check_result();
            end
            if (req_valid_i && req_ready_i === 1'b1) begin
                record_request();
                seen_req <= 1'b1;
            end
            if (end_i && !end_done) begin
                report_missing();
                end_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_tb
    import exec_pkg::*;
();

    localparam int MAX_VEC    = 64;
    localparam int FIELDS     = 10;
    localparam int WAIT_LIMIT = 2000;

    logic                clk;
    logic                rst;
    logic                req_valid;
    exec_req_t           req;
    logic                req_ready;
    logic                res_valid;
    exec_res_t           res;
    logic                res_ready;
    logic                check_end;
    logic [2**TAG_W-1:0] tag_busy;
    int                  value_errors;
    int                  tag_errors;
    int                  missing_errors;
    int                  protocol_errors;
    int                  run_errors;
    int                  num_vec;
    integer              seed;
    logic [XLEN-1:0]     vec_mem [0:MAX_VEC*FIELDS-1];

    exec_top UUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .res_valid_o (res_valid),
        .res_o       (res),
        .res_ready_i (res_ready)
    );

    exec_checker #(.MAX_VEC(MAX_VEC)) u_checker (
        .clk               (clk),
        .rst               (rst),
        .req_valid_i       (req_valid),
        .req_ready_i       (req_ready),
        .req_i             (req),
        .res_valid_i       (res_valid),
        .res_ready_i       (res_ready),
        .res_i             (res),
        .end_i             (check_end),
        .tag_busy_o        (tag_busy),
        .value_errors_o    (value_errors),
        .tag_errors_o      (tag_errors),
        .missing_errors_o  (missing_errors),
        .protocol_errors_o (protocol_errors)
    );

    initial clk = 1'b0;

    always #2 clk = ~clk;

    // sink accepts about three cycles in four
    always @(negedge clk) begin
        res_ready = (($random(seed) & 3) != 0);
    end

    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VEC && !$isunknown(vec_mem[n*FIELDS])) begin
            n++;
        end
        return n;
    endfunction

    // drives one vector and returns right after the edge that takes it
    task automatic issue_vector(input int idx);
        exec_req_t vec_req;
        int        base;
        int        waited;
        base            = idx * FIELDS;
        vec_req.op      = exec_op_e'(vec_mem[base][5:0]);
        vec_req.tag     = vec_mem[base+1][TAG_W-1:0];
        vec_req.rd      = vec_mem[base+2][4:0];
        vec_req.pc      = vec_mem[base+3];
        vec_req.rs1_val = vec_mem[base+4];
        vec_req.rs2_val = vec_mem[base+5];
        vec_req.imm     = vec_mem[base+6];
        waited          = 0;
        @(negedge clk);
        // a tag is reused only after its earlier result has left
        while (tag_busy[vec_req.tag] && waited < WAIT_LIMIT) begin
            req_valid = 1'b0;
            waited++;
            @(negedge clk);
        end
        if (tag_busy[vec_req.tag]) begin
            $display("timed out waiting for tag %0h to retire before vector %0d",
                     vec_req.tag, idx);
            run_errors++;
        end else begin
            req       = vec_req;
            req_valid = 1'b1;
            waited    = 0;
            #1;
            while (!req_ready && waited < WAIT_LIMIT) begin
                waited++;
                @(negedge clk);
                #1;
            end
            if (!req_ready) begin
                $display("timed out waiting for the DUT to accept vector %0d", idx);
                run_errors++;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic wait_results_drained();
        int waited;
        waited = 0;
        while (tag_busy != '0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (tag_busy != '0) begin
            $display("timed out waiting for outstanding results, busy tags %h", tag_busy);
            run_errors++;
        end
    endtask

    initial begin
        int idx;
        int total;
        seed       = 32'h80c4;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        res_ready  = 1'b0;
        check_end  = 1'b0;
        run_errors = 0;
        $readmemh("verif/exec_vectors.txt", vec_mem);
        num_vec = count_vectors();
        if (num_vec == 0) begin
            $display("no vectors could be read from verif/exec_vectors.txt");
            run_errors++;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle stretch, res_valid_o has to stay low here
        repeat (5) @(negedge clk);
        idx = 0;
        while (idx < num_vec && run_errors == 0) begin
            issue_vector(idx);
            idx++;
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait_results_drained();
        check_end = 1'b1;
        @(posedge clk);
        @(negedge clk);
        total = value_errors + tag_errors + missing_errors + protocol_errors + run_errors;
        $display("errors: value %0d, tag %0d, missing %0d, protocol %0d, run %0d",
                 value_errors, tag_errors, missing_errors, protocol_errors, run_errors);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/exec_vectors.txt
// op tag rd pc rs1 rs2 imm | expected value redirect target, all hex
// op is the exec_op_e code, e.g. 00 add, 0f mul, 14 div, 1c beq, 23 jalr
14 0 01 0 fffffffffffffff9 2 0 fffffffffffffffd 0 0 // div, long latency first
00 1 02 0 7fffffffffffffff 1 0 8000000000000000 0 0 // add
01 2 03 0 3 5 0 fffffffffffffffe 0 0 // sub
02 3 04 0 f0f0 ff00 0 f000 0 0 // and
03 4 05 0 f0f0 0f0f 0 ffff 0 0 // or
04 5 06 0 ff00 0ff0 0 f0f0 0 0 // xor
05 6 07 0 1 41 0 2 0 0 // sll, amount masked to 1
06 7 08 0 8000000000000000 3f 0 1 0 0 // srl
07 8 09 0 8000000000000000 4 0 f800000000000000 0 0 // sra
08 9 0a 0 ffffffffffffffff 1 0 1 0 0 // slt
09 a 0b 0 ffffffffffffffff 1 0 0 0 0 // sltu
0f b 0c 0 fffffffffffffffd 5 0 fffffffffffffff1 0 0 // mul
0a c 0d 0 7fffffff 1 0 ffffffff80000000 0 0 // addw
0b d 0e 0 1234567800000000 1 0 ffffffffffffffff 0 0 // subw
0c e 0f 0 1 3f 0 ffffffff80000000 0 0 // sllw, amount masked to 31
0d f 10 0 ffffffff80000000 24 0 08000000 0 0 // srlw, amount masked to 4
0e 0 11 0 80000000 4 0 fffffffff8000000 0 0 // sraw
10 1 12 0 c000000000000000 fffffffffffffff8 0 2 0 0 // mulh
1c 2 13 1000 5 5 10 1004 1 1010 // beq taken
1d 3 14 1000 5 5 ffffffffffffff00 1004 0 f00 // bne not taken
15 4 15 0 64 7 0 e 0 0 // divu
1e 5 16 2000 ffffffffffffffff 1 8 2004 1 2008 // blt taken
1f 6 17 2000 ffffffffffffffff 1 8 2004 0 2008 // bge not taken
20 7 18 2000 ffffffffffffffff 1 8 2004 0 2008 // bltu not taken
21 8 19 2000 ffffffffffffffff 1 8 2004 1 2008 // bgeu taken
11 9 1a 0 ffffffffffffffff ffffffffffffffff 0 ffffffffffffffff 0 0 // mulhsu
16 a 1b 0 fffffffffffffff9 2 0 ffffffffffffffff 0 0 // rem
22 b 1c 3000 0 0 100 3004 1 3100 // jal
23 c 1d 3000 4001 0 4 3004 1 4004 // jalr, bit 0 cleared
12 d 1e 0 ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe 0 0 // mulhu
17 e 1f 0 64 7 0 2 0 0 // remu
13 f 01 0 0000000100000003 00000000fffffffe 0 fffffffffffffffa 0 0 // mulw
18 0 02 0 80000000 ffffffff 0 ffffffff80000000 0 0 // divw, word overflow
19 1 03 0 fffffffffffffff0 10 0 0fffffff 0 0 // divuw
1a 2 04 0 00000000fffffff9 3 0 ffffffffffffffff 0 0 // remw
1b 3 05 0 fffffff9 a 0 9 0 0 // remuw
14 4 06 0 1234 0 0 ffffffffffffffff 0 0 // div by zero
16 5 07 0 fffffffffffffffb 0 0 fffffffffffffffb 0 0 // rem by zero
14 6 08 0 8000000000000000 ffffffffffffffff 0 8000000000000000 0 0 // div overflow
16 7 09 0 8000000000000000 ffffffffffffffff 0 0 0 0 // rem overflow
1a 8 0a 0 80000001 0 0 ffffffff80000001 0 0 // remw by zero

//--- src.f
source/exec_pkg.sv
source/exec_dispatch.sv
source/alu_unit.sv
source/mul_unit.sv
source/div_unit.sv
source/branch_unit.sv
source/result_arbiter.sv
source/exec_top.sv
verif/exec_checker.sv
verif/exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - source/exec_pkg.sv
  - source/exec_dispatch.sv
  - source/alu_unit.sv
  - source/mul_unit.sv
  - source/div_unit.sv
  - source/branch_unit.sv
  - source/result_arbiter.sv
  - source/exec_top.sv
  - target: simulation
    files:
      - verif/exec_checker.sv
      - verif/exec_tb.sv
